//--- logic/alu.sv
`timescale 1ns/100ps

module alu (
  input  logic [stack_pkg::data_width-1:0] a,
  input  logic [stack_pkg::data_width-1:0] b,
  input  stack_pkg::alu_op_e               op,
  output logic [stack_pkg::data_width-1:0] result
);
  import stack_pkg::*;

  // a is the stack top or an address base
  // b is the second entry or the immediate
  logic [3:0] shamt;
  logic [2*data_width-1:0] product;

  // shift distance from b only
  assign shamt = b[3:0];
  assign product = a * b;

  always_comb begin
    case (op)
      alu_pass_a: result = a;
      alu_pass_b: result = b;
      alu_inc:    result = a + 16'd1;
      alu_inc2:   result = a + 16'd2;
      alu_not_a:  result = ~a;
      // flip sign bit, for offset-binary compares
      alu_sign:   result = a ^ 16'h8000;
      alu_exts:   result = {{8{a[7]}}, a[7:0]};
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_shr:    result = a >> shamt;
      alu_sar:    result = $signed(a) >>> shamt;
      alu_shl:    result = a << shamt;
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      // low half of the product only
      alu_mul:    result = product[data_width-1:0];
      // compares give 0 or 1
      alu_eq:     result = data_width'(a == b);
      alu_neq:    result = data_width'(a != b);
      alu_lt:     result = data_width'($signed(a) < $signed(b));
      alu_le:     result = data_width'($signed(a) <= $signed(b));
      alu_bt:     result = data_width'(a < b);
      alu_be:     result = data_width'(a <= b);
      // unknown codes behave as nop
      default:    result = a;
    endcase
  end

endmodule

//--- logic/control_sequencer.sv
`timescale 1ns/100ps

module control_sequencer (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [stack_pkg::insn_width-1:0] insn,
  input  logic                             top_zero,
  output stack_pkg::phase_e                phase,
  output stack_pkg::alu_op_e               alu_op,
  output stack_pkg::src_a_e                src_a_sel,
  output stack_pkg::src_b_e                src_b_sel,
  output logic [stack_pkg::data_width-1:0] imm_mask,
  output logic                             imm_sign,
  output logic                             push,
  output logic                             pop,
  output logic                             load_stk,
  output logic                             cpush,
  output logic                             cpop,
  output logic                             load_fp,
  output logic                             load_ip,
  output logic                             load_insn,
  output logic                             rd_mem,
  output logic                             wr_mem,
  output logic                             byt,
  output logic                             wr_stk1,
  output logic                             halted
);
  import stack_pkg::*;

  // end-of-program mark, shadows push ffffeh
  localparam logic [insn_width-1:0] halt_code = 18'h3fffe;

  phase_e next_phase;
  logic [1:0] x_sel;
  logic is_halt, is_push_imm, is_binop, is_call, is_jmp, is_add_fp, is_jz;
  logic is_ld1, is_st1, is_ldst, is_push_x, is_stk_op, is_misc, is_ld, is_st;

  // instruction classes from the top bits
  assign is_halt     = (insn == halt_code);
  assign is_push_imm = (insn[17:16] == 2'b11) && !is_halt;
  assign is_binop    = (insn[17:16] == 2'b10);
  assign is_call     = (insn[17:14] == 4'b0000);
  assign is_jmp      = (insn[17:12] == 6'b000100);
  assign is_add_fp   = (insn[17:12] == 6'b000101);
  assign is_jz       = (insn[17:12] == 6'b000110);
  assign is_ld1      = (insn[17:14] == 4'b0010);
  assign is_st1      = (insn[17:14] == 4'b0011);
  assign is_ldst     = (insn[17:14] == 4'b0100);
  assign is_push_x   = (insn[17:14] == 4'b0101);
  assign is_stk_op   = (insn[17:11] == 7'b0111000);
  assign is_misc     = (insn[17:11] == 7'b0111001);
  // word ld/st split on bit 0, offset is even
  assign is_ld       = is_ld1 || (is_ldst && !insn[0]);
  assign is_st       = is_st1 || (is_ldst && insn[0]);
  // base register for memory forms
  assign x_sel       = insn[13:12];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      phase <= ph_fetch;
    end else begin
      phase <= next_phase;
    end
  end

  always_comb begin
    case (phase)
      ph_fetch: next_phase = ph_exec;
      ph_exec: begin
        if (is_halt) begin
          next_phase = ph_halt;
        end else if (is_ld) begin
          next_phase = ph_load;
        end else begin
          next_phase = ph_fetch;
        end
      end
      ph_load: next_phase = ph_fetch;
      // halt holds until reset
      default: next_phase = ph_halt;
    endcase
  end

  always_comb begin
    alu_op    = alu_pass_a;
    src_a_sel = src_a_stk;
    src_b_sel = src_b_stk1;
    imm_mask  = 16'h0fff;
    imm_sign  = 1'b0;
    push      = 1'b0;
    pop       = 1'b0;
    load_stk  = 1'b0;
    cpush     = 1'b0;
    cpop      = 1'b0;
    load_fp   = 1'b0;
    load_ip   = 1'b0;
    load_insn = 1'b0;
    rd_mem    = 1'b0;
    wr_mem    = 1'b0;
    byt       = 1'b0;
    case (phase)
      ph_fetch: begin
        // latch insn, step ip past it
        load_insn = 1'b1;
        load_ip   = 1'b1;
        src_a_sel = src_a_ip;
        alu_op    = alu_inc;
      end
      ph_exec: begin
        if (is_push_imm) begin
          src_b_sel = src_b_imm;
          imm_mask  = 16'hffff;
          alu_op    = alu_pass_b;
          push      = 1'b1;
        end else if (is_binop) begin
          // top op uimm10
          src_b_sel = src_b_imm;
          imm_mask  = 16'h03ff;
          alu_op    = alu_op_e'(insn[15:10]);
          load_stk  = 1'b1;
        end else if (is_call) begin
          // return address through alu, target from immediate
          src_a_sel = src_a_ip;
          src_b_sel = src_b_imm;
          imm_mask  = 16'h3fff;
          cpush     = 1'b1;
          load_ip   = 1'b1;
        end else if (is_jmp || is_add_fp || is_jz) begin
          src_a_sel = is_add_fp ? src_a_fp : src_a_ip;
          src_b_sel = src_b_imm;
          imm_sign  = insn[11];
          alu_op    = alu_add;
          load_fp   = is_add_fp;
          // jz always drops the tested value
          load_ip   = is_jmp || (is_jz && top_zero);
          pop       = is_jz;
        end else if (is_ld1 || is_st1 || is_ldst || is_push_x) begin
          src_a_sel = src_a_e'(x_sel);
          src_b_sel = src_b_imm;
          imm_mask  = is_ldst ? 16'h0ffe : 16'h0fff;
          // X=0 means absolute address
          alu_op    = (x_sel == 2'd0) ? alu_pass_b : alu_add;
          byt       = is_ld1 || is_st1;
          rd_mem    = is_ld;
          wr_mem    = is_st;
          pop       = is_st;
          push      = is_push_x;
        end else if (is_stk_op) begin
          alu_op    = alu_op_e'(insn[5:0]);
          push      = insn[7];
          pop       = insn[6];
          load_stk  = 1'b1;
        end else if (is_misc) begin
          case (insn[9:0])
            // ret
            10'h000: begin
              src_a_sel = src_a_cstk;
              cpop      = 1'b1;
              load_ip   = 1'b1;
            end
            // cpop fp
            10'h002: begin
              src_a_sel = src_a_cstk;
              cpop      = 1'b1;
              load_fp   = 1'b1;
            end
            // cpush fp
            10'h003: begin
              src_a_sel = src_a_fp;
              cpush     = 1'b1;
            end
            default: ;
          endcase
        end
      end
      ph_load: begin
        // read data arrives now, push it
        push = 1'b1;
        byt  = is_ld1;
      end
      default: ;
    endcase
  end

  // only indirect stores take data from entry 1, none decoded here
  assign wr_stk1 = 1'b0;
  assign halted  = (phase == ph_halt);

  a_mem_onehot: assert property (@(posedge clk) disable iff (rst) !(rd_mem && wr_mem));
  a_insn_fetch: assert property (@(posedge clk) disable iff (rst)
    load_insn |-> phase == ph_fetch);

endmodule

//--- logic/cpu.sv
`timescale 1ns/100ps

module cpu #(
  parameter int addr_width = 14
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [stack_pkg::insn_width-1:0] rd_pmem,
  input  logic [stack_pkg::data_width-1:0] rd_data,
  output logic [stack_pkg::data_width-1:0] pmem_addr,
  output logic [addr_width-1:0]            mem_addr,
  output logic                             rd_mem,
  output logic                             wr_mem,
  output logic                             byt,
  output logic [stack_pkg::data_width-1:0] wr_data,
  output logic                             halted
);
  import stack_pkg::*;

  phase_e phase;
  alu_op_e alu_op;
  src_a_e src_a_sel;
  src_b_e src_b_sel;
  logic [data_width-1:0] imm_mask, imm;
  logic imm_sign, push, pop, load_stk, cpush, cpop, load_fp, load_ip, load_insn, wr_stk1;
  logic [data_width-1:0] fp, ip, ip_in;
  logic [insn_width-1:0] insn;
  // lane of the last data access
  logic addr0_d;
  logic [data_width-1:0] stack0, stack1, cstack0;
  logic [data_width-1:0] src_a, src_b, alu_out, stack_in, rd_fmt, wr_raw;

  // immediate field, sign fill above the mask
  assign imm = (insn[15:0] & imm_mask) | (imm_sign ? ~imm_mask : '0);

  always_comb begin
    case (src_a_sel)
      src_a_fp:   src_a = fp;
      src_a_ip:   src_a = ip;
      src_a_cstk: src_a = cstack0;
      default:    src_a = stack0;
    endcase
  end

  assign src_b = (src_b_sel == src_b_imm) ? imm : stack1;

  // byte reads come back zero-extended
  assign rd_fmt = !byt ? rd_data
                : addr0_d ? {8'h00, rd_data[15:8]}
                : {8'h00, rd_data[7:0]};
  assign stack_in = (phase == ph_load) ? rd_fmt : alu_out;

  // call takes its target from the immediate, alu carries ip to cstack
  assign ip_in = cpush ? src_b : alu_out;
  // program ram registers its read, so present the next ip early
  assign pmem_addr = load_ip ? ip_in : ip;

  assign mem_addr = alu_out[addr_width-1:0];
  assign wr_raw = wr_stk1 ? stack1 : stack0;
  // odd byte store goes in the high lane
  assign wr_data = (byt && mem_addr[0]) ? {wr_raw[7:0], 8'h00} : wr_raw;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      fp   <= fp_reset;
      ip   <= '0;
      insn <= '0;
    end else begin
      if (load_fp) begin
        fp <= alu_out;
      end
      if (load_ip) begin
        ip <= ip_in;
      end
      if (load_insn) begin
        insn <= rd_pmem;
      end
    end
  end

  always_ff @(posedge clk) begin
    addr0_d <= mem_addr[0];
  end

  alu u_alu (
    .a      (src_a),
    .b      (src_b),
    .op     (alu_op),
    .result (alu_out)
  );

  // operand stack
  stack u_stack (
    .clk     (clk),
    .rst     (rst),
    .push    (push),
    .pop     (pop),
    .load    (load_stk),
    .data_in (stack_in),
    .data0   (stack0),
    .data1   (stack1)
  );

  // return addresses and saved fp
  stack u_cstack (
    .clk     (clk),
    .rst     (rst),
    .push    (cpush),
    .pop     (cpop),
    .load    (cpush),
    .data_in (alu_out),
    .data0   (cstack0),
    .data1   ()
  );

  control_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .insn      (insn),
    .top_zero  (stack0 == '0),
    .phase     (phase),
    .alu_op    (alu_op),
    .src_a_sel (src_a_sel),
    .src_b_sel (src_b_sel),
    .imm_mask  (imm_mask),
    .imm_sign  (imm_sign),
    .push      (push),
    .pop       (pop),
    .load_stk  (load_stk),
    .cpush     (cpush),
    .cpop      (cpop),
    .load_fp   (load_fp),
    .load_ip   (load_ip),
    .load_insn (load_insn),
    .rd_mem    (rd_mem),
    .wr_mem    (wr_mem),
    .byt       (byt),
    .wr_stk1   (wr_stk1),
    .halted    (halted)
  );

endmodule

//--- logic/mcu_top.sv
`timescale 1ns/100ps

module mcu_top #(
  parameter int          prog_depth    = 1024,
  parameter int          data_depth    = 8192,
  parameter logic [15:0] out_port_addr = 16'h0082
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             prog_we,
  input  logic [$clog2(prog_depth)-1:0]    prog_addr,
  input  logic [stack_pkg::insn_width-1:0] prog_data,
  output logic [7:0]                       out_port,
  output logic                             out_valid,
  output logic                             halted
);
  import stack_pkg::*;

  localparam int prog_aw = $clog2(prog_depth);
  localparam int data_aw = $clog2(data_depth);
  // byte address into data memory
  localparam int addr_width = data_aw + 1;

  logic [data_width-1:0] pmem_addr, wr_data, rd_data;
  logic [insn_width-1:0] rd_pmem;
  logic [addr_width-1:0] mem_addr;
  logic rd_mem, wr_mem, byt, port_hit;
  logic [1:0] prog_ram_we, data_we;
  logic [prog_aw-1:0] prog_ram_addr;

  // loader owns program ram in reset, parks on 0 for the first fetch
  assign prog_ram_we = (rst && prog_we) ? 2'b11 : 2'b00;
  assign prog_ram_addr = !rst ? pmem_addr[prog_aw-1:0]
                       : prog_we ? prog_addr
                       : '0;

  // port write bypasses data ram
  assign port_hit = wr_mem && (mem_addr == out_port_addr[addr_width-1:0]);
  assign data_we = (!wr_mem || port_hit) ? 2'b00
                 : !byt ? 2'b11
                 : mem_addr[0] ? 2'b10 : 2'b01;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_port  <= 8'h00;
    end else begin
      out_valid <= port_hit;
      if (port_hit) begin
        out_port <= wr_data[7:0];
      end
    end
  end

  cpu #(
    .addr_width (addr_width)
  ) u_cpu (
    .clk       (clk),
    .rst       (rst),
    .rd_pmem   (rd_pmem),
    .rd_data   (rd_data),
    .pmem_addr (pmem_addr),
    .mem_addr  (mem_addr),
    .rd_mem    (rd_mem),
    .wr_mem    (wr_mem),
    .byt       (byt),
    .wr_data   (wr_data),
    .halted    (halted)
  );

  sync_ram #(
    .width (insn_width),
    .depth (prog_depth)
  ) u_pmem (
    .clk   (clk),
    .we    (prog_ram_we),
    .addr  (prog_ram_addr),
    .wdata (prog_data),
    .rdata (rd_pmem)
  );

  sync_ram #(
    .width (data_width),
    .depth (data_depth)
  ) u_dmem (
    .clk   (clk),
    .we    (data_we),
    .addr  (mem_addr[addr_width-1:1]),
    .wdata (wr_data),
    .rdata (rd_data)
  );

  a_load_in_reset: assert property (@(posedge clk) prog_we |-> rst);
  // output port is write only
  a_port_no_read: assert property (@(posedge clk) disable iff (rst)
    !(rd_mem && mem_addr == out_port_addr[addr_width-1:0]));

endmodule

//--- logic/stack.sv
`timescale 1ns/100ps

module stack #(
  parameter int depth = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             push,
  input  logic                             pop,
  input  logic                             load,
  input  logic [stack_pkg::data_width-1:0] data_in,
  output logic [stack_pkg::data_width-1:0] data0,
  output logic [stack_pkg::data_width-1:0] data1
);
  import stack_pkg::*;

  // entry 0 is the top
  logic [data_width-1:0] regs [depth];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (push) begin
      for (int i = depth - 1; i > 0; i--) begin
        regs[i] <= regs[i-1];
      end
      regs[0] <= data_in;
    end else if (pop) begin
      for (int i = 0; i < depth - 1; i++) begin
        regs[i] <= regs[i+1];
      end
      regs[depth-1] <= '0;
      // binop forms overwrite the entry that moves up
      if (load) begin
        regs[0] <= data_in;
      end
    end else if (load) begin
      regs[0] <= data_in;
    end
  end

  assign data0 = regs[0];
  assign data1 = regs[1];

  // decode never asks for both directions at once
  a_push_pop: assert property (@(posedge clk) disable iff (rst) !(push && pop));

endmodule

//--- logic/stack_pkg.sv
package stack_pkg;

  // machine word and instruction word
  localparam int data_width = 16;
  localparam int insn_width = 18;

  // frame starts at top of data memory and grows toward 0
  localparam logic [data_width-1:0] fp_reset = 16'h4000;

  // alu functions, coded as the low six bits of the stack-only form
  typedef enum logic [5:0] {
    alu_pass_a = 6'h00,
    alu_inc    = 6'h01,
    alu_inc2   = 6'h02,
    alu_not_a  = 6'h04,
    alu_sign   = 6'h05,
    alu_exts   = 6'h06,
    alu_pass_b = 6'h0f,
    alu_and    = 6'h10,
    alu_or     = 6'h11,
    alu_xor    = 6'h12,
    alu_shr    = 6'h14,
    alu_sar    = 6'h15,
    alu_shl    = 6'h16,
    alu_add    = 6'h20,
    alu_sub    = 6'h21,
    alu_mul    = 6'h22,
    alu_eq     = 6'h28,
    alu_neq    = 6'h29,
    alu_lt     = 6'h2a,
    alu_le     = 6'h2b,
    alu_bt     = 6'h2c,
    alu_be     = 6'h2d
  } alu_op_e;

  // alu input a, same order as the X field of the memory forms
  typedef enum logic [1:0] {
    src_a_stk  = 2'd0,
    src_a_fp   = 2'd1,
    src_a_ip   = 2'd2,
    src_a_cstk = 2'd3
  } src_a_e;

  // alu input b
  typedef enum logic [1:0] {
    src_b_stk1 = 2'd0,
    src_b_imm  = 2'd1
  } src_b_e;

  typedef enum logic [1:0] {
    ph_fetch = 2'd0,
    ph_exec  = 2'd1,
    ph_load  = 2'd2,
    ph_halt  = 2'd3
  } phase_e;

endpackage

//--- logic/sync_ram.sv
`timescale 1ns/100ps

module sync_ram #(
  parameter int width = 16,
  parameter int depth = 1024
) (
  input  logic                     clk,
  input  logic [1:0]               we,
  input  logic [$clog2(depth)-1:0] addr,
  input  logic [width-1:0]         wdata,
  output logic [width-1:0]         rdata
);

  // byte lanes only for the 16-bit data word
  localparam bit byte_lanes = (width == 16);

  logic [width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (byte_lanes) begin
      if (we[0]) begin
        mem[addr][7:0] <= wdata[7:0];
      end
      if (we[1]) begin
        mem[addr][width-1:8] <= wdata[width-1:8];
      end
    end else if (|we) begin
      mem[addr] <= wdata;
    end
    // read returns old contents on a write
    rdata <= mem[addr];
  end

endmodule

//--- sim.f
logic/stack_pkg.sv
logic/alu.sv
logic/stack.sv
logic/control_sequencer.sv
logic/cpu.sv
logic/sync_ram.sv
logic/mcu_top.sv
sim/tb_mcu.sv

//--- sim/tb_mcu.sv
`timescale 1ns/100ps

module tb_mcu;
  import stack_pkg::*;

  localparam int prog_depth = 1024;
  localparam int data_depth = 8192;
  localparam int prog_aw = $clog2(prog_depth);
  localparam logic [15:0] port_addr = 16'h0082;
  // fp right after reset, frame grows down
  localparam logic [15:0] fp_start = 16'h4000;
  localparam int halt_timeout = 2000;

  // opcode fields of the kept instruction forms
  localparam logic [5:0] jmp_code = 6'b000100;
  localparam logic [5:0] addfp_code = 6'b000101;
  localparam logic [5:0] jz_code = 6'b000110;
  localparam logic [3:0] ld1_code = 4'b0010;
  localparam logic [3:0] st1_code = 4'b0011;
  localparam logic [3:0] ldst_code = 4'b0100;
  localparam logic [3:0] pushx_code = 4'b0101;
  localparam logic [17:0] ret_insn = 18'h1c800;
  localparam logic [17:0] halt_insn = 18'h3fffe;
  // word st, absolute address, bit 0 marks the store
  localparam logic [17:0] store_port = {ldst_code, 2'd0, port_addr[11:0] | 12'h001};

  logic clk;
  logic rst;
  logic prog_we;
  logic [prog_aw-1:0] prog_addr;
  logic [17:0] prog_data;
  logic [7:0] out_port;
  logic out_valid;
  logic halted;

  // program image, built before loading
  logic [17:0] prog [$];
  // expected port bytes in write order
  logic [7:0] exp_bytes [64];
  int exp_total = 0;
  // port writes seen so far, also the read index into exp_bytes
  int out_count = 0;
  int errors = 0;

  mcu_top #(
    .prog_depth    (prog_depth),
    .data_depth    (data_depth),
    .out_port_addr (port_addr)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .out_port  (out_port),
    .out_valid (out_valid),
    .halted    (halted)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (!rst && out_valid) begin
      out_count <= out_count + 1;
    end
  end

  // quiet outputs in reset and the cycle after
  a_reset_quiet: assert property (@(posedge clk) (rst || $past(rst)) |-> !out_valid && !halted)
    else begin
      errors++;
      $display("out_valid or halted went high during or just after reset");
    end

  // each port write must match the next expected byte
  a_out_byte: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (out_count < exp_total) && (out_port == exp_bytes[out_count]))
    else begin
      errors++;
      $display("Fail: out_port expected %h actual %h",
               exp_bytes[$sampled(out_count)], $sampled(out_port));
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst) $past(halted) |-> halted)
    else begin
      errors++;
      $display("halted dropped before reset");
    end

  a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst) halted |-> !out_valid)
    else begin
      errors++;
      $display("port written after the core halted");
    end

  // every expected byte consumed by the time halt shows
  a_all_out_seen: assert property (@(posedge clk) disable iff (rst)
    $rose(halted) |-> out_count == exp_total)
    else begin
      errors++;
      $display("halted with %0d of %0d port writes", $sampled(out_count), exp_total);
    end

  function automatic logic [17:0] push_imm(input logic [15:0] value);
    return {2'b11, value};
  endfunction

  // stack-only form, a is the top and b the entry below
  function automatic logic [17:0] stack_op(input alu_op_e fn, input logic psh, input logic pp);
    return {7'b0111000, 3'b000, psh, pp, fn};
  endfunction

  // top op uimm10, result replaces the top
  function automatic logic [17:0] binop_imm(input alu_op_e fn, input logic [9:0] value);
    return {2'b10, fn, value};
  endfunction

  // jmp, add fp and jz share the simm12 layout
  function automatic logic [17:0] rel_form(input logic [5:0] code, input logic [11:0] offset);
    return {code, offset};
  endfunction

  // X+uimm12 forms, X=1 is fp
  function automatic logic [17:0] mem_form(input logic [3:0] code, input logic [1:0] x,
                                           input logic [11:0] offset);
    return {code, x, offset};
  endfunction

  task automatic put(input logic [17:0] insn);
    prog.push_back(insn);
  endtask

  task automatic expect_byte(input logic [15:0] word);
    exp_bytes[exp_total] = word[7:0];
    exp_total++;
  endtask

  // push b then a, apply fn, send the result to the port
  task automatic alu_case(input alu_op_e fn, input logic [15:0] b, input logic [15:0] a,
                          input logic [15:0] result);
    put(push_imm(b));
    put(push_imm(a));
    put(stack_op(fn, 1'b0, 1'b1));
    put(store_port);
    expect_byte(result);
  endtask

  task automatic build_program();
    int loop_at;
    int call_at;
    alu_case(alu_add, 16'h1234, 16'h0f0f, 16'h2143);
    alu_case(alu_sub, 16'h0003, 16'h0100, 16'h00fd);
    alu_case(alu_mul, 16'h0013, 16'h0107, 16'h1385);
    alu_case(alu_xor, 16'h00f0, 16'h005a, 16'h00aa);
    alu_case(alu_shl, 16'h0003, 16'h0011, 16'h0088);
    // sign fill shows in the low byte
    alu_case(alu_sar, 16'h000c, 16'h8000, 16'hfff8);
    // same operands, signed then unsigned
    alu_case(alu_lt, 16'h0001, 16'hffff, 16'h0001);
    alu_case(alu_bt, 16'h0001, 16'hffff, 16'h0000);
    // open a 16 byte frame, word at fp+4
    put(rel_form(addfp_code, 12'hff0));
    put(push_imm(16'h1234));
    put(mem_form(ldst_code, 2'd1, 12'h005));
    // byte into the high lane of that word
    put(push_imm(16'h00a5));
    put(mem_form(st1_code, 2'd1, 12'h005));
    put(mem_form(ldst_code, 2'd1, 12'h004));
    put(stack_op(alu_pass_a, 1'b1, 1'b0));
    put(store_port);
    expect_byte(16'h0034);
    put(binop_imm(alu_shr, 10'd8));
    put(store_port);
    expect_byte(16'h00a5);
    // byte load, sar exposes any sign extension
    put(mem_form(ld1_code, 2'd1, 12'h005));
    put(binop_imm(alu_sar, 10'd4));
    put(store_port);
    expect_byte(16'h00a5 >> 4);
    put(rel_form(addfp_code, 12'h010));
    // countdown, jz offsets count from the next insn
    put(push_imm(16'd5));
    loop_at = prog.size();
    put(stack_op(alu_pass_a, 1'b1, 1'b0));
    put(store_port);
    put(binop_imm(alu_sub, 10'd1));
    put(stack_op(alu_pass_a, 1'b1, 1'b0));
    put(rel_form(jz_code, 12'd1));
    put(rel_form(jmp_code, 12'(loop_at - prog.size() - 1)));
    // drop the final zero
    put(stack_op(alu_pass_b, 1'b0, 1'b1));
    for (int n = 5; n > 0; n--) begin
      expect_byte(16'(n));
    end
    // subroutine sits right after halt, 7 words on
    call_at = prog.size();
    put({4'b0000, 14'(call_at + 7)});
    put(push_imm(16'h0077));
    put(store_port);
    put(rel_form(addfp_code, 12'hff6));
    put(mem_form(pushx_code, 2'd1, 12'h000));
    put(store_port);
    put(halt_insn);
    put(push_imm(16'h005a));
    put(store_port);
    put(ret_insn);
    expect_byte(16'h005a);
    expect_byte(16'h0077);
    expect_byte(fp_start - 16'd10);
  endtask

  initial begin
    int cycles;
    clk = 1'b0;
    rst = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    build_program();
    // loader writes one word per cycle while rst is high
    foreach (prog[i]) begin
      @(negedge clk);
      prog_we = 1'b1;
      prog_addr = prog_aw'(i);
      prog_data = prog[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
    // 4 plain reset cycles, ram parked on word 0
    repeat (4) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while (!halted && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("timeout: program never halted within %0d cycles", halt_timeout);
    end
    // a few more edges for the halt checks
    repeat (4) @(negedge clk);
    $display("errors: %0d, port writes %0d of %0d expected", errors, out_count, exp_total);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
